// File: hw/div_pkg.sv
// divider package with widths, opcode and phase encodings, and the adder request types
`default_nettype none

package div_pkg;

    // operand width and iteration count
    localparam int DATA_W = 32;
    localparam int STEPS  = 32;
    localparam int CNT_W  = 6;

    // funct3 codes of the M extension divide group
    // bit 0 marks unsigned, bit 1 marks remainder
    typedef enum logic [2:0] {
        DIV  = 3'd4,
        DIVU = 3'd5,
        REM  = 3'd6,
        REMU = 3'd7
    } div_op_e;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        PRE  = 3'd1,
        BUSY = 3'd2,
        FIX  = 3'd3
    } div_phase_e;

    // command flags captured at accept
    typedef struct packed {
        logic want_rem;
        logic dvd_neg;
        logic dvs_neg;
    } div_cmd_t;

    // one request to the shared adder
    typedef struct packed {
        logic [DATA_W-1:0] operand;
        logic [DATA_W-1:0] addend;
        logic              carry_in;
    } add_req_t;

endpackage

`default_nettype wire

// File: hw/div_control.sv
// divider phase FSM and step counter with stall handling
`timescale 1ns/10ps
`default_nettype none

module div_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       op_valid,
    input  logic                       op_stall,
    output div_pkg::div_phase_e        phase,
    output logic [div_pkg::CNT_W-1:0]  count,
    output logic                       adv,
    output logic                       op_ready
);

    // idle only moves on a valid command, every other phase moves unless stalled
    assign adv = ~op_stall & ((phase != div_pkg::IDLE) | op_valid);

    // result is on the bus during the single fix cycle
    assign op_ready = (phase == div_pkg::FIX) & ~op_stall;

    //////////////////////////////
    // phase and counter
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= div_pkg::IDLE;
            count <= '0;
        end else if (adv) begin
            case (phase)
                div_pkg::IDLE: begin
                    phase <= div_pkg::PRE;
                end
                div_pkg::PRE: begin
                    phase <= div_pkg::BUSY;
                    count <= div_pkg::CNT_W'(div_pkg::STEPS);
                end
                div_pkg::BUSY: begin
                    count <= count - div_pkg::CNT_W'(1);
                    // last step brings the count to zero
                    if (count == div_pkg::CNT_W'(1)) begin
                        phase <= div_pkg::FIX;
                    end
                end
                div_pkg::FIX: begin
                    phase <= div_pkg::IDLE;
                end
                default: begin
                    phase <= div_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/div_operand_latch.sv
// divider operand latch, captures command flags and builds the operand magnitudes
`timescale 1ns/10ps
`default_nettype none

module div_operand_latch (
    input  logic                        clk,
    input  logic                        arst_n,
    input  div_pkg::div_phase_e         phase,
    input  logic                        adv,
    input  div_pkg::div_op_e            op,
    input  logic [div_pkg::DATA_W-1:0]  op1,
    input  logic [div_pkg::DATA_W-1:0]  op2,
    input  logic [div_pkg::DATA_W-1:0]  sum,
    output div_pkg::div_cmd_t           cmd,
    output logic [div_pkg::DATA_W-1:0]  divisor,
    output div_pkg::add_req_t           req
);

    logic              accept;
    logic              pre_adv;
    div_pkg::div_cmd_t cmd_d;

    assign accept  = (phase == div_pkg::IDLE) & adv;
    assign pre_adv = (phase == div_pkg::PRE) & adv;

    // decode of the live opcode
    assign cmd_d.want_rem = op[1];
    assign cmd_d.dvd_neg  = ~op[0] & op1[div_pkg::DATA_W-1];
    assign cmd_d.dvs_neg  = ~op[0] & op2[div_pkg::DATA_W-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd <= '0;
        end else if (accept) begin
            cmd <= cmd_d;
        end
    end

    // raw op2 first, its magnitude one cycle later
    always_ff @(posedge clk) begin
        if (accept) begin
            divisor <= op2;
        end else if (pre_adv) begin
            divisor <= sum;
        end
    end

    // two's complement magnitude, invert and carry in when negative
    always_comb begin
        req.addend = '0;
        if (phase == div_pkg::PRE) begin
            req.operand  = cmd.dvs_neg ? ~divisor : divisor;
            req.carry_in = cmd.dvs_neg;
        end else begin
            req.operand  = cmd_d.dvd_neg ? ~op1 : op1;
            req.carry_in = cmd_d.dvd_neg;
        end
    end

endmodule

`default_nettype wire

// File: hw/div_iterate.sv
// restoring divider datapath, one quotient bit per step
`timescale 1ns/10ps
`default_nettype none

module div_iterate (
    input  logic                        clk,
    input  logic                        arst_n,
    input  div_pkg::div_phase_e         phase,
    input  logic                        adv,
    input  logic [div_pkg::DATA_W-1:0]  divisor,
    input  logic [div_pkg::DATA_W-1:0]  sum,
    output logic [div_pkg::DATA_W-1:0]  quot,
    output logic [div_pkg::DATA_W-1:0]  rem,
    output div_pkg::add_req_t           req
);

    // remainder in the high half, quotient shifts in from the bottom
    logic [2*div_pkg::DATA_W-1:0] acc;
    logic [2*div_pkg::DATA_W-1:0] acc_sl;
    logic                         take;

    assign acc_sl = {acc[2*div_pkg::DATA_W-2:0], 1'b0};

    // the bit shifted out of the top means the partial remainder already exceeds
    // any 32-bit divisor, the modular difference still fits in the high half
    assign take = acc[2*div_pkg::DATA_W-1] |
                  (acc_sl[2*div_pkg::DATA_W-1:div_pkg::DATA_W] >= divisor);

    // high half minus divisor
    assign req.operand  = acc_sl[2*div_pkg::DATA_W-1:div_pkg::DATA_W];
    assign req.addend   = ~divisor;
    assign req.carry_in = 1'b1;

    //////////////////////////////
    // shift and subtract
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (adv) begin
            if (phase == div_pkg::IDLE) begin
                // dividend magnitude from the adder
                acc <= {{div_pkg::DATA_W{1'b0}}, sum};
            end else if (phase == div_pkg::BUSY) begin
                if (take) begin
                    acc <= {sum, acc_sl[div_pkg::DATA_W-1:1], 1'b1};
                end else begin
                    acc <= acc_sl;
                end
            end
        end
    end

    assign quot = acc[div_pkg::DATA_W-1:0];
    assign rem  = acc[2*div_pkg::DATA_W-1:div_pkg::DATA_W];

endmodule

`default_nettype wire

// File: hw/div_adder_arbiter.sv
// phase based arbiter for the single shared 32-bit adder
`timescale 1ns/10ps
`default_nettype none

module div_adder_arbiter (
    input  div_pkg::div_phase_e         phase,
    input  div_pkg::add_req_t           lat_req,
    input  div_pkg::add_req_t           itr_req,
    input  div_pkg::add_req_t           res_req,
    output logic [div_pkg::DATA_W-1:0]  sum
);

    div_pkg::add_req_t grant;

    // owner of the adder in each phase
    always_comb begin
        case (phase)
            div_pkg::IDLE: begin
                grant = lat_req;
            end
            div_pkg::PRE: begin
                grant = lat_req;
            end
            div_pkg::BUSY: begin
                grant = itr_req;
            end
            div_pkg::FIX: begin
                grant = res_req;
            end
            default: begin
                grant = lat_req;
            end
        endcase
    end

    //////////////////////////////
    // the adder
    //////////////////////////////
    assign sum = grant.operand + grant.addend + div_pkg::DATA_W'(grant.carry_in);

endmodule

`default_nettype wire

// File: hw/div_result.sv
// divider result stage, selects quotient or remainder and fixes its sign
`timescale 1ns/10ps
`default_nettype none

module div_result (
    input  div_pkg::div_cmd_t           cmd,
    input  logic [div_pkg::DATA_W-1:0]  divisor,
    input  logic [div_pkg::DATA_W-1:0]  quot,
    input  logic [div_pkg::DATA_W-1:0]  rem,
    input  logic [div_pkg::DATA_W-1:0]  sum,
    output div_pkg::add_req_t           req,
    output logic [div_pkg::DATA_W-1:0]  op_out
);

    logic [div_pkg::DATA_W-1:0] sel;
    logic                       div_zero;
    logic                       neg;

    assign sel      = cmd.want_rem ? rem : quot;
    assign div_zero = (divisor == '0);

    // remainder follows the dividend sign
    // quotient of a divide by zero stays all ones
    assign neg = cmd.want_rem ? cmd.dvd_neg : ((cmd.dvd_neg ^ cmd.dvs_neg) & ~div_zero);

    assign req.operand  = neg ? ~sel : sel;
    assign req.addend   = '0;
    assign req.carry_in = neg;

    assign op_out = sum;

endmodule

`default_nettype wire

// File: hw/div_top.sv
// iterative RV32M divider top level around one shared adder
`timescale 1ns/10ps
`default_nettype none

module div_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        op_valid,
    input  logic                        op_stall,
    input  div_pkg::div_op_e            op,
    input  logic [div_pkg::DATA_W-1:0]  op1,
    input  logic [div_pkg::DATA_W-1:0]  op2,
    output logic                        op_ready,
    output logic [div_pkg::DATA_W-1:0]  op_out
);

    div_pkg::div_phase_e        phase;
    logic                       adv;
    div_pkg::div_cmd_t          cmd;
    logic [div_pkg::DATA_W-1:0] divisor;
    logic [div_pkg::DATA_W-1:0] quot;
    logic [div_pkg::DATA_W-1:0] rem;
    logic [div_pkg::DATA_W-1:0] sum;
    div_pkg::add_req_t          lat_req;
    div_pkg::add_req_t          itr_req;
    div_pkg::add_req_t          res_req;

    div_control i_control (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .op_stall (op_stall),
        .phase    (phase),
        .count    (),
        .adv      (adv),
        .op_ready (op_ready)
    );

    div_operand_latch i_operand_latch (
        .clk     (clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .adv     (adv),
        .op      (op),
        .op1     (op1),
        .op2     (op2),
        .sum     (sum),
        .cmd     (cmd),
        .divisor (divisor),
        .req     (lat_req)
    );

    div_iterate i_iterate (
        .clk     (clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .adv     (adv),
        .divisor (divisor),
        .sum     (sum),
        .quot    (quot),
        .rem     (rem),
        .req     (itr_req)
    );

    div_adder_arbiter i_adder_arbiter (
        .phase   (phase),
        .lat_req (lat_req),
        .itr_req (itr_req),
        .res_req (res_req),
        .sum     (sum)
    );

    div_result i_result (
        .cmd     (cmd),
        .divisor (divisor),
        .quot    (quot),
        .rem     (rem),
        .sum     (sum),
        .req     (res_req),
        .op_out  (op_out)
    );

endmodule

`default_nettype wire

// File: test/div_sva.sv
// handshake assertions for the divider top level, bound into div_top
`timescale 1ns/10ps
`default_nettype none

module div_sva (
    input logic clk,
    input logic arst_n,
    input logic op_stall,
    input logic op_ready
);

    // a stalled cycle never carries a result
    property p_no_ready_in_stall;
        @(posedge clk) disable iff (!arst_n) op_stall |-> !op_ready;
    endproperty

    // result strobe lasts one cycle
    property p_ready_pulse;
        @(posedge clk) disable iff (!arst_n) op_ready |=> !op_ready;
    endproperty

    property p_quiet_in_reset;
        @(posedge clk) !arst_n |-> !op_ready;
    endproperty

    a_no_ready_in_stall: assert property (p_no_ready_in_stall)
        else $error("op_ready high while op_stall is high");
    a_ready_pulse: assert property (p_ready_pulse)
        else $error("op_ready held high for more than one cycle");
    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("op_ready high during reset");

endmodule

`default_nettype wire

// File: test/div_tb.sv
// testbench for the iterative RV32M divider, pattern file tests plus LCG operands
`timescale 1ns/10ps
`default_nettype none

module div_tb;

    localparam int MAX_PAT  = 64;
    localparam int N_RAND   = 12;
    // cycles from the accept edge to the result, FIX cycle included
    localparam int LATENCY  = 34;
    localparam int STALL_AT = 10;

    logic                        clk;
    logic                        arst_n;
    logic                        op_valid;
    logic                        op_stall;
    div_pkg::div_op_e            op;
    logic [div_pkg::DATA_W-1:0]  op1;
    logic [div_pkg::DATA_W-1:0]  op2;
    logic                        op_ready;
    logic [div_pkg::DATA_W-1:0]  op_out;

    logic [31:0] pat_mem [0:5*MAX_PAT-1];
    int          n_pat;
    int          max_gap;
    int          cycle_cnt;
    int          cycle_limit;
    int          pass_cnt;
    int          fail_cnt;
    int          err_cnt;
    logic        fix_exit_pending;
    logic [31:0] lcg_state;

    div_top i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .op_stall (op_stall),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .op_ready (op_ready),
        .op_out   (op_out)
    );

    bind div_top div_sva i_sva (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_stall (op_stall),
        .op_ready (op_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unsigned quotient or remainder of a nonzero divisor
    function automatic logic [31:0] model_result(input logic [2:0] code,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        return code[1] ? (a % b) : (a / b);
    endfunction

    function automatic string op_name(input logic [2:0] code);
        case (code)
            3'd4:    return "DIV ";
            3'd5:    return "DIVU";
            3'd6:    return "REM ";
            default: return "REMU";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s got %08h expected %08h", name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    //////////////////////////////
    // one command through the DUT
    //////////////////////////////
    task automatic run_test(input int idx, input logic [2:0] code, input logic [31:0] a,
                            input logic [31:0] b, input int gap, input logic [31:0] exp,
                            input int idle_gap);
        int   cyc;
        int   stall_left;
        int   exp_lat;
        logic got;
        err_cnt = 0;
        exp_lat = LATENCY + gap;
        if (idle_gap > 0) begin
            repeat (idle_gap) @(negedge clk);
            fix_exit_pending = 1'b0;
        end
        op       = div_pkg::div_op_e'(code);
        op1      = a;
        op2      = b;
        op_valid = 1'b1;
        op_stall = 1'b0;
        // the DUT leaves FIX before it can accept a back to back command
        if (fix_exit_pending) begin
            @(posedge clk);
        end
        @(posedge clk);
        cyc        = 0;
        stall_left = gap;
        got        = 1'b0;
        while (!got && cyc < exp_lat + 4) begin
            @(negedge clk);
            cyc      = cyc + 1;
            op_valid = 1'b0;
            if (op_ready) begin
                got = 1'b1;
            end else if (cyc >= STALL_AT && stall_left > 0) begin
                op_stall   = 1'b1;
                stall_left = stall_left - 1;
            end else begin
                op_stall = 1'b0;
            end
        end
        if (!got) begin
            $display("op_ready did not rise within %0d cycles of the accept", exp_lat + 4);
            err_cnt = err_cnt + 1;
        end else begin
            check_value("op_ready latency", cyc, exp_lat);
            check_value("op_out", op_out, exp);
        end
        fix_exit_pending = got;
        op_stall         = 1'b0;
        if (err_cnt == 0) begin
            pass_cnt = pass_cnt + 1;
            $display("test %0d %s %08h %08h gap %0d ok", idx, op_name(code), a, b, gap);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d %s %08h %08h gap %0d FAILED", idx, op_name(code), a, b, gap);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  code;
        logic        done;
        int          i;
        cycle_cnt        = 0;
        cycle_limit      = 0;
        pass_cnt         = 0;
        fail_cnt         = 0;
        err_cnt          = 0;
        fix_exit_pending = 1'b0;
        lcg_state        = 32'h7a3f;
        arst_n           = 1'b0;
        op_valid         = 1'b0;
        op_stall         = 1'b0;
        op               = div_pkg::DIV;
        op1              = '0;
        op2              = '0;

        $readmemh("test/div_patterns.hex", pat_mem);
        // count entries up to the first one without a divide opcode
        n_pat   = 0;
        max_gap = 0;
        done    = 1'b0;
        while (!done && n_pat < MAX_PAT) begin
            if (pat_mem[5*n_pat] >= 32'd4 && pat_mem[5*n_pat] <= 32'd7) begin
                if (int'(pat_mem[5*n_pat+3]) > max_gap) begin
                    max_gap = int'(pat_mem[5*n_pat+3]);
                end
                n_pat = n_pat + 1;
            end else begin
                done = 1'b1;
            end
        end
        if (n_pat == 0) begin
            $display("no tests were read from the pattern file");
            fail_cnt = fail_cnt + 1;
        end
        cycle_limit = (n_pat + N_RAND) * (LATENCY + max_gap + 4) + 20;

        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        for (i = 0; i < n_pat; i = i + 1) begin
            run_test(i, pat_mem[5*i][2:0], pat_mem[5*i+1], pat_mem[5*i+2],
                     int'(pat_mem[5*i+3]), pat_mem[5*i+4], (i % 3 == 0) ? 2 : 0);
        end

        // unsigned operands of varied magnitude issued back to back
        for (i = 0; i < N_RAND; i = i + 1) begin
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state;
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state >> lcg_state[31:27];
            code      = (i % 2 == 1) ? 3'd7 : 3'd5;
            run_test(n_pat + i, code, a, b, 0, model_result(code, a, b), 0);
        end

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: div.f
hw/div_pkg.sv
hw/div_control.sv
hw/div_operand_latch.sv
hw/div_iterate.sv
hw/div_adder_arbiter.sv
hw/div_result.sv
hw/div_top.sv
test/div_sva.sv
test/div_tb.sv

// File: Makefile
TOP := div_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

obj_dir/V$(TOP): div.f hw/*.sv test/*.sv
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f div.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -Wno-fatal --timescale 1ns/10ps \
		-f div.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: test/div_patterns.hex
// columns: op (funct3) op1 op2 stall-gap expected-op_out
// op 4 DIV, 5 DIVU, 6 REM, 7 REMU
5 00000064 00000007 00 0000000e
7 00000064 00000007 00 00000002
5 ffffffff 00000010 00 0fffffff
7 ffffffff 00000010 00 0000000f
5 80000000 00000003 00 2aaaaaaa
7 80000000 00000003 00 00000002
4 00000064 00000007 00 0000000e
6 00000064 00000007 00 00000002
4 ffffff9c 00000007 00 fffffff2
6 ffffff9c 00000007 00 fffffffe
4 00000064 fffffff9 00 fffffff2
6 00000064 fffffff9 00 00000002
4 ffffff9c fffffff9 00 0000000e
6 ffffff9c fffffff9 00 fffffffe
4 ffffffff 00000002 00 00000000
6 ffffffff 00000002 00 ffffffff
4 7fffffff 80000000 00 00000000
6 7fffffff 80000000 00 7fffffff
4 00001234 00000000 00 ffffffff
5 80000001 00000000 00 ffffffff
6 ffffff9c 00000000 00 ffffff9c
7 00001234 00000000 00 00001234
4 ffffff9c 00000000 00 ffffffff
4 80000000 ffffffff 00 80000000
6 80000000 ffffffff 00 00000000
4 ffffff9c 00000007 03 fffffff2
7 ffffffff 00000010 05 0000000f
5 80000000 00000003 01 2aaaaaaa
